/* source/shtp_macros.svh */
`ifndef SHTP_MACROS_SVH
`define SHTP_MACROS_SVH

// ======================================================================
// Board timings in clock cycles
// ======================================================================
`define SHTP_RESET_WAIT      19'd300000  // Hub boot time after reset
`define SHTP_INT_TIMEOUT     19'd600     // Longest INT wait while initializing
`define SHTP_CMD_GAP         19'd30000   // Idle time after each command

// ======================================================================
// SHTP framing and protocol values
// ======================================================================
`define SHTP_HDR_BYTES       4
`define SHTP_MAX_LEN         16'd32766

// Channels
`define SHTP_CHAN_CONTROL    8'h02
`define SHTP_CHAN_REPORTS    8'h03
`define SHTP_CHAN_GYRO_RV    8'h05

// Report IDs
`define SHTP_ID_ROT_VEC      8'h05
`define SHTP_ID_GYRO         8'h02       // Calibrated gyroscope
`define SHTP_ID_SET_FEATURE  8'hFD
`define SHTP_ID_PROD_REQ     8'hF9

`define SHTP_INTERVAL_US     32'd20000   // 50 Hz report rate

`endif

/* source/shtp_pkg.sv */
package shtp_pkg;

    typedef logic [7:0]         shtp_byte_t;    // One SPI byte
    typedef logic [15:0]        shtp_len_t;     // SHTP length field
    typedef logic [7:0]         shtp_cnt_t;     // Byte position within a stream
    typedef logic signed [15:0] sensor_word_t;  // Fixed-point axis value

    // Initialization commands in send order
    typedef enum logic [1:0] {
        PROD_ID,
        EN_ROT_VEC,
        EN_GYRO
    } cmd_sel_t;

    // Delay limits of the shared timer
    typedef enum logic [1:0] {
        DLY_RESET,
        DLY_INT,
        DLY_GAP
    } delay_sel_t;

    typedef enum logic [3:0] {
        ST_RESET_WAIT,  // Power-up wait
        ST_INIT_INT,    // INT wait with timeout
        ST_INIT_SEND,   // Command bytes out
        ST_INIT_GAP,    // Pause after a command
        ST_WAIT_DATA,
        ST_HEADER,
        ST_PAYLOAD,
        ST_ERROR
    } seq_state_t;

endpackage

/* source/shtp_rx_if.sv */
`timescale 1ns/100ps

interface shtp_rx_if;
    import shtp_pkg::*;

    logic       byte_strobe;  // One cycle per received packet byte
    shtp_byte_t byte_data;
    logic       in_header;
    shtp_cnt_t  byte_idx;     // Header index or payload index

    modport sequencer (
        output byte_strobe, byte_data, in_header, byte_idx
    );

    modport parser (
        input  byte_strobe, byte_data, in_header, byte_idx
    );

endinterface

/* source/shtp_timer.sv */
`timescale 1ns/100ps
`include "shtp_macros.svh"

module shtp_timer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  shtp_pkg::delay_sel_t sel,
    output logic                 expired
);
    import shtp_pkg::*;

    logic [18:0] count;
    logic [18:0] limit;

    always_comb begin
        case (sel)
            DLY_RESET: limit = `SHTP_RESET_WAIT;
            DLY_INT:   limit = `SHTP_INT_TIMEOUT;
            default:   limit = `SHTP_CMD_GAP;
        endcase
    end

    // Holds at the limit until the next clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count < limit) begin
            count <= count + 19'd1;
        end
    end

    assign expired = (count == limit) && !clear;  // Stale count ignored while clearing

endmodule

/* source/init_cmd_rom.sv */
`timescale 1ns/100ps
`include "shtp_macros.svh"

module init_cmd_rom (
    input  shtp_pkg::cmd_sel_t   cmd,
    input  shtp_pkg::shtp_cnt_t  idx,
    output shtp_pkg::shtp_byte_t cmd_byte,
    output logic                 last
);
    import shtp_pkg::*;

    localparam shtp_cnt_t   PROD_LEN = 8'd5;   // Header plus request ID
    localparam shtp_cnt_t   FEAT_LEN = 8'd17;  // Header plus set-feature body
    localparam logic [31:0] INTERVAL = `SHTP_INTERVAL_US;

    shtp_byte_t report_id;
    shtp_byte_t seq_num;

    // Both set-feature streams differ only in these two bytes
    assign report_id = (cmd == EN_GYRO) ? `SHTP_ID_GYRO : `SHTP_ID_ROT_VEC;
    assign seq_num   = (cmd == EN_GYRO) ? 8'd2 : 8'd1;

    always_comb begin
        if (cmd == PROD_ID) begin
            last = (idx == PROD_LEN - 8'd1);
            case (idx)
                8'd0:    cmd_byte = PROD_LEN;            // Length LSB
                8'd2:    cmd_byte = `SHTP_CHAN_CONTROL;
                8'd4:    cmd_byte = `SHTP_ID_PROD_REQ;
                default: cmd_byte = 8'h00;               // Length MSB and sequence
            endcase
        end else begin
            last = (idx == FEAT_LEN - 8'd1);
            case (idx)
                8'd0:    cmd_byte = FEAT_LEN;
                8'd2:    cmd_byte = `SHTP_CHAN_CONTROL;
                8'd3:    cmd_byte = seq_num;
                8'd4:    cmd_byte = `SHTP_ID_SET_FEATURE;
                8'd5:    cmd_byte = report_id;
                // Report interval, little-endian
                8'd9:    cmd_byte = INTERVAL[7:0];
                8'd10:   cmd_byte = INTERVAL[15:8];
                8'd11:   cmd_byte = INTERVAL[23:16];
                8'd12:   cmd_byte = INTERVAL[31:24];
                default: cmd_byte = 8'h00;               // Flags, sensitivity, batch interval
            endcase
        end
    end

endmodule

/* source/shtp_sequencer.sv */
`timescale 1ns/100ps
`include "shtp_macros.svh"

module shtp_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 int_n,
    input  logic                 spi_busy,
    input  logic                 spi_rx_valid,
    input  shtp_pkg::shtp_byte_t spi_rx_data,
    output logic                 spi_start,
    output shtp_pkg::shtp_byte_t spi_tx_data,
    output logic                 cs_n,
    output logic                 initialized,
    output logic                 error,
    output logic                 timer_clear,
    output shtp_pkg::delay_sel_t timer_sel,
    input  logic                 timer_expired,
    output shtp_pkg::cmd_sel_t   cmd,
    output shtp_pkg::shtp_cnt_t  cmd_idx,
    input  shtp_pkg::shtp_byte_t cmd_byte,
    input  logic                 cmd_last,
    shtp_rx_if.sequencer         rx
);
    import shtp_pkg::*;

    seq_state_t state;
    logic       int_meta;
    logic       int_sync;
    logic       pending;   // Byte in flight on the SPI master
    logic       xfer_go;
    logic       reading;
    shtp_cnt_t  byte_cnt;
    shtp_len_t  pkt_len;
    shtp_len_t  remain;    // Payload bytes still to read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    assign xfer_go = !pending && !spi_busy && !spi_start;
    assign reading = (state == ST_HEADER) || (state == ST_PAYLOAD);

    always_comb begin
        case (state)
            ST_RESET_WAIT: timer_sel = DLY_RESET;
            ST_INIT_INT:   timer_sel = DLY_INT;
            default:       timer_sel = DLY_GAP;
        endcase
    end

    // ======================================================================
    // Main FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_RESET_WAIT;
            cs_n        <= 1'b1;
            spi_start   <= 1'b0;
            spi_tx_data <= 8'h00;
            pending     <= 1'b0;
            initialized <= 1'b0;
            error       <= 1'b0;
            timer_clear <= 1'b0;
            cmd         <= PROD_ID;
            cmd_idx     <= 8'd0;
            byte_cnt    <= 8'd0;
            pkt_len     <= 16'd0;
            remain      <= 16'd0;
        end else begin
            spi_start   <= 1'b0;
            timer_clear <= 1'b0;
            if (spi_rx_valid) begin
                pending <= 1'b0;
            end

            case (state)
                ST_RESET_WAIT: begin
                    if (timer_expired) begin
                        timer_clear <= 1'b1;
                        state       <= ST_INIT_INT;
                    end
                end

                ST_INIT_INT: begin
                    if (!int_sync) begin
                        cs_n    <= 1'b0;
                        cmd_idx <= 8'd0;
                        state   <= ST_INIT_SEND;
                    end else if (timer_expired) begin
                        error <= 1'b1;  // Hub never signalled ready
                        state <= ST_ERROR;
                    end
                end

                ST_INIT_SEND: begin
                    if (xfer_go) begin
                        spi_start   <= 1'b1;
                        spi_tx_data <= cmd_byte;
                        pending     <= 1'b1;
                    end
                    if (spi_rx_valid) begin
                        if (cmd_last) begin
                            cs_n        <= 1'b1;
                            timer_clear <= 1'b1;
                            state       <= ST_INIT_GAP;
                        end else begin
                            cmd_idx <= cmd_idx + 8'd1;
                        end
                    end
                end

                ST_INIT_GAP: begin
                    if (timer_expired) begin
                        if (cmd == EN_GYRO) begin
                            initialized <= 1'b1;
                            state       <= ST_WAIT_DATA;
                        end else begin
                            cmd         <= cmd_sel_t'(cmd + 2'd1);
                            timer_clear <= 1'b1;
                            state       <= ST_INIT_INT;
                        end
                    end
                end

                ST_WAIT_DATA: begin
                    if (!int_sync) begin
                        cs_n     <= 1'b0;
                        byte_cnt <= 8'd0;
                        state    <= ST_HEADER;
                    end
                end

                ST_HEADER: begin
                    if (xfer_go) begin
                        spi_start   <= 1'b1;
                        spi_tx_data <= 8'h00;
                        pending     <= 1'b1;
                    end
                    if (spi_rx_valid) begin
                        byte_cnt <= byte_cnt + 8'd1;
                        if (byte_cnt == 8'd0) begin
                            pkt_len[7:0] <= spi_rx_data;
                        end else if (byte_cnt == 8'd1) begin
                            pkt_len[15:8] <= {1'b0, spi_rx_data[6:0]};  // Continuation bit masked
                        end
                        if (byte_cnt == 8'(`SHTP_HDR_BYTES - 1)) begin
                            byte_cnt <= 8'd0;
                            remain   <= pkt_len - 16'(`SHTP_HDR_BYTES);
                            if (pkt_len > 16'(`SHTP_HDR_BYTES) && pkt_len <= `SHTP_MAX_LEN) begin
                                state <= ST_PAYLOAD;
                            end else begin
                                cs_n  <= 1'b1;  // Empty or corrupt packet
                                state <= ST_WAIT_DATA;
                            end
                        end
                    end
                end

                ST_PAYLOAD: begin
                    if (xfer_go) begin
                        spi_start   <= 1'b1;
                        spi_tx_data <= 8'h00;
                        pending     <= 1'b1;
                    end
                    if (spi_rx_valid) begin
                        if (byte_cnt != 8'hFF) begin
                            byte_cnt <= byte_cnt + 8'd1;  // Saturates on long packets
                        end
                        remain <= remain - 16'd1;
                        if (remain == 16'd1) begin
                            cs_n  <= 1'b1;
                            state <= ST_WAIT_DATA;
                        end
                    end
                end

                ST_ERROR: cs_n <= 1'b1;  // Sticky until reset

                default: state <= ST_ERROR;
            endcase
        end
    end

    // ======================================================================
    // Byte forwarding to the report parser
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx.byte_strobe <= 1'b0;
            rx.in_header   <= 1'b0;
            rx.byte_idx    <= 8'd0;
        end else begin
            rx.byte_strobe <= spi_rx_valid && reading;
            rx.in_header   <= (state == ST_HEADER);
            rx.byte_idx    <= byte_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (spi_rx_valid) begin
            rx.byte_data <= spi_rx_data;
        end
    end

endmodule

/* source/report_parser.sv */
`timescale 1ns/100ps
`include "shtp_macros.svh"

module report_parser (
    input  logic                   clk,
    input  logic                   rst_n,
    shtp_rx_if.parser              rx,
    output logic                   quat_valid,
    output shtp_pkg::sensor_word_t quat_w,
    output shtp_pkg::sensor_word_t quat_x,
    output shtp_pkg::sensor_word_t quat_y,
    output shtp_pkg::sensor_word_t quat_z,
    output logic                   gyro_valid,
    output shtp_pkg::sensor_word_t gyro_x,
    output shtp_pkg::sensor_word_t gyro_y,
    output shtp_pkg::sensor_word_t gyro_z
);
    import shtp_pkg::*;

    shtp_byte_t   channel;
    shtp_byte_t   report_id;
    shtp_byte_t   low_byte;   // Pending LSB of the current field
    logic         accept;
    logic         is_quat;
    logic         is_gyro;
    logic         payload;
    sensor_word_t word;

    assign accept  = (channel == `SHTP_CHAN_REPORTS) || (channel == `SHTP_CHAN_GYRO_RV);
    assign is_quat = accept && (report_id == `SHTP_ID_ROT_VEC);
    assign is_gyro = accept && (report_id == `SHTP_ID_GYRO);
    assign payload = rx.byte_strobe && !rx.in_header;
    assign word    = sensor_word_t'({rx.byte_data, low_byte});  // Little-endian join

    // Fields start on even payload bytes
    always_ff @(posedge clk) begin
        if (payload && !rx.byte_idx[0]) begin
            low_byte <= rx.byte_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            channel    <= 8'h00;
            report_id  <= 8'h00;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
            quat_w     <= '0;
            quat_x     <= '0;
            quat_y     <= '0;
            quat_z     <= '0;
            gyro_x     <= '0;
            gyro_y     <= '0;
            gyro_z     <= '0;
        end else begin
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
            if (rx.byte_strobe && rx.in_header && rx.byte_idx == 8'd2) begin
                channel <= rx.byte_data;
            end
            if (payload) begin
                case (rx.byte_idx)
                    8'd0: report_id <= rx.byte_data;
                    8'd5: begin
                        if (is_quat) quat_x <= word;
                        if (is_gyro) gyro_x <= word;
                    end
                    8'd7: begin
                        if (is_quat) quat_y <= word;
                        if (is_gyro) gyro_y <= word;
                    end
                    8'd9: begin
                        if (is_quat) quat_z <= word;
                        if (is_gyro) begin
                            gyro_z     <= word;
                            gyro_valid <= 1'b1;  // Gyro report complete
                        end
                    end
                    8'd11: begin
                        if (is_quat) begin
                            quat_w     <= word;
                            quat_valid <= 1'b1;  // Quaternion complete
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* source/bno085_controller.sv */
`timescale 1ns/100ps

module bno085_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    // SPI master byte handshake
    output logic                   spi_start,
    output shtp_pkg::shtp_byte_t   spi_tx_data,
    input  logic                   spi_busy,
    input  logic                   spi_rx_valid,
    input  shtp_pkg::shtp_byte_t   spi_rx_data,
    output logic                   cs_n,
    input  logic                   int_n,        // Hub data ready, active low
    // Sensor outputs
    output logic                   quat_valid,
    output shtp_pkg::sensor_word_t quat_w,
    output shtp_pkg::sensor_word_t quat_x,
    output shtp_pkg::sensor_word_t quat_y,
    output shtp_pkg::sensor_word_t quat_z,
    output logic                   gyro_valid,
    output shtp_pkg::sensor_word_t gyro_x,
    output shtp_pkg::sensor_word_t gyro_y,
    output shtp_pkg::sensor_word_t gyro_z,
    output logic                   initialized,
    output logic                   error
);
    import shtp_pkg::*;

    logic       timer_clear;
    logic       timer_expired;
    delay_sel_t timer_sel;
    cmd_sel_t   cmd;
    shtp_cnt_t  cmd_idx;
    shtp_byte_t cmd_byte;
    logic       cmd_last;

    shtp_rx_if rx_bus ();

    shtp_sequencer i_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .int_n         (int_n),
        .spi_busy      (spi_busy),
        .spi_rx_valid  (spi_rx_valid),
        .spi_rx_data   (spi_rx_data),
        .spi_start     (spi_start),
        .spi_tx_data   (spi_tx_data),
        .cs_n          (cs_n),
        .initialized   (initialized),
        .error         (error),
        .timer_clear   (timer_clear),
        .timer_sel     (timer_sel),
        .timer_expired (timer_expired),
        .cmd           (cmd),
        .cmd_idx       (cmd_idx),
        .cmd_byte      (cmd_byte),
        .cmd_last      (cmd_last),
        .rx            (rx_bus.sequencer)
    );

    shtp_timer i_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (timer_clear),
        .sel     (timer_sel),
        .expired (timer_expired)
    );

    init_cmd_rom i_cmd_rom (
        .cmd      (cmd),
        .idx      (cmd_idx),
        .cmd_byte (cmd_byte),
        .last     (cmd_last)
    );

    report_parser i_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx_bus.parser),
        .quat_valid (quat_valid),
        .quat_w     (quat_w),
        .quat_x     (quat_x),
        .quat_y     (quat_y),
        .quat_z     (quat_z),
        .gyro_valid (gyro_valid),
        .gyro_x     (gyro_x),
        .gyro_y     (gyro_y),
        .gyro_z     (gyro_z)
    );

endmodule

/* test/tb_bno085_controller.sv */
`timescale 1ns/100ps
`include "shtp_macros.svh"

module tb_bno085_controller;
    import shtp_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         int_n;
    logic         spi_start;
    shtp_byte_t   spi_tx_data;
    logic         spi_busy;
    logic         spi_rx_valid;
    shtp_byte_t   spi_rx_data;
    logic         cs_n;
    logic         quat_valid;
    logic         gyro_valid;
    logic         initialized;
    logic         error;
    sensor_word_t quat_w;
    sensor_word_t quat_x;
    sensor_word_t quat_y;
    sensor_word_t quat_z;
    sensor_word_t gyro_x;
    sensor_word_t gyro_y;
    sensor_word_t gyro_z;

    shtp_byte_t   tx_log[$];   // Every byte the DUT sent
    shtp_byte_t   pkt_q[$];    // Bytes the hub still has to return
    shtp_byte_t   exp_init[$];
    logic [15:0]  exp_q[4];    // X Y Z W
    logic [15:0]  exp_g[3];
    integer       seed = 32'h1a91_dacd;
    int           quat_pulses = 0;
    int           quat_cycles = 0;
    int           gyro_pulses = 0;
    int           gyro_cycles = 0;
    logic         quat_prev = 1'b0;
    logic         gyro_prev = 1'b0;

    bno085_controller i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .spi_start    (spi_start),
        .spi_tx_data  (spi_tx_data),
        .spi_busy     (spi_busy),
        .spi_rx_valid (spi_rx_valid),
        .spi_rx_data  (spi_rx_data),
        .cs_n         (cs_n),
        .int_n        (int_n),
        .quat_valid   (quat_valid),
        .quat_w       (quat_w),
        .quat_x       (quat_x),
        .quat_y       (quat_y),
        .quat_z       (quat_z),
        .gyro_valid   (gyro_valid),
        .gyro_x       (gyro_x),
        .gyro_y       (gyro_y),
        .gyro_z       (gyro_z),
        .initialized  (initialized),
        .error        (error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // SPI master and hub model
    // ======================================================================
    task automatic serve_byte;
        shtp_byte_t reply;
        tx_log.push_back(spi_tx_data);
        reply = (pkt_q.size() > 0) ? pkt_q.pop_front() : 8'h00;
        #1 spi_busy = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        spi_busy     = 1'b0;
        spi_rx_valid = 1'b1;
        spi_rx_data  = reply;
        @(posedge clk);
        #1 spi_rx_valid = 1'b0;
    endtask

    initial begin
        spi_busy     = 1'b0;
        spi_rx_valid = 1'b0;
        spi_rx_data  = 8'h00;
        forever begin
            @(posedge clk);
            if (spi_start) serve_byte();
        end
    end

    // Pulse and width counters for the valid strobes
    always @(posedge clk) begin
        if (quat_valid) quat_cycles++;
        if (quat_valid && !quat_prev) quat_pulses++;
        if (gyro_valid) gyro_cycles++;
        if (gyro_valid && !gyro_prev) gyro_pulses++;
        quat_prev = quat_valid;
        gyro_prev = gyro_valid;
    end

    // ======================================================================
    // Checks and waits
    // ======================================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s expected %h, got %h", name, expected, actual));
        end
    endtask

    task automatic check_outputs;
        check_value("quat_x", exp_q[0], $unsigned(quat_x));
        check_value("quat_y", exp_q[1], $unsigned(quat_y));
        check_value("quat_z", exp_q[2], $unsigned(quat_z));
        check_value("quat_w", exp_q[3], $unsigned(quat_w));
        check_value("gyro_x", exp_g[0], $unsigned(gyro_x));
        check_value("gyro_y", exp_g[1], $unsigned(gyro_y));
        check_value("gyro_z", exp_g[2], $unsigned(gyro_z));
    endtask

    task automatic wait_cs(input logic level, input int limit, input string what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = (cs_n === level);
            n++;
        end
        if (!seen) abort_run($sformatf("Timed out waiting for %s", what));
    endtask

    // Error wait also watches that chip select never drops
    task automatic wait_status(input logic want_error, input int limit, input string what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = want_error ? (error === 1'b1) : (initialized === 1'b1);
            if (want_error) check_value("cs_n", 32'd1, cs_n);
            n++;
        end
        if (!seen) abort_run($sformatf("Timed out waiting for %s", what));
    endtask

    task automatic apply_reset;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        exp_q = '{16'h0, 16'h0, 16'h0, 16'h0};
        exp_g = '{16'h0, 16'h0, 16'h0};
        @(posedge clk);
        #1;
        check_value("cs_n", 32'd1, cs_n);
        check_value("spi_start", 32'd0, spi_start);
        check_value("quat_valid", 32'd0, quat_valid);
        check_value("gyro_valid", 32'd0, gyro_valid);
        check_value("initialized", 32'd0, initialized);
        check_value("error", 32'd0, error);
        check_outputs();
    endtask

    // ======================================================================
    // Initialization commands
    // ======================================================================
    task automatic push_feature(input shtp_byte_t seq, input shtp_byte_t id);
        logic [31:0] iv;
        int          k;
        iv = `SHTP_INTERVAL_US;
        exp_init.push_back(8'd17);                // Length LSB
        exp_init.push_back(8'h00);
        exp_init.push_back(`SHTP_CHAN_CONTROL);
        exp_init.push_back(seq);
        exp_init.push_back(`SHTP_ID_SET_FEATURE);
        exp_init.push_back(id);
        for (k = 0; k < 3; k++) exp_init.push_back(8'h00);
        for (k = 0; k < 4; k++) exp_init.push_back(iv[8*k +: 8]);
        for (k = 0; k < 4; k++) exp_init.push_back(8'h00);  // Batch interval
    endtask

    task automatic run_init;
        int ends[3];
        int c;
        int k;
        int unsigned delay;
        exp_init = {8'd5, 8'h00, `SHTP_CHAN_CONTROL, 8'h00, `SHTP_ID_PROD_REQ};
        ends[0] = exp_init.size();
        push_feature(8'd1, `SHTP_ID_ROT_VEC);
        ends[1] = exp_init.size();
        push_feature(8'd2, `SHTP_ID_GYRO);
        ends[2] = exp_init.size();

        repeat (`SHTP_RESET_WAIT) @(posedge clk);
        for (c = 0; c < 3; c++) begin
            if (c > 0) repeat (`SHTP_CMD_GAP) @(posedge clk);
            delay = $unsigned($random(seed)) % (`SHTP_INT_TIMEOUT - 100);
            repeat (delay) @(posedge clk);
            #1 int_n = 1'b0;
            wait_cs(1'b0, `SHTP_INT_TIMEOUT, "chip select low for an init command");
            #1 int_n = 1'b1;
            wait_cs(1'b1, 400, "end of an init command");
            check_value("bytes at cs_n rise", ends[c], tx_log.size());
        end
        wait_status(1'b0, `SHTP_CMD_GAP + 100, "initialized after the last gap");
        check_value("error", 32'd0, error);
        check_value("init bytes sent", 32'd39, tx_log.size());
        for (k = 0; k < ends[2]; k++) begin
            check_value($sformatf("init spi_tx_data[%0d]", k), exp_init[k], tx_log[k]);
        end
    endtask

    // ======================================================================
    // Packet reads from the case file
    // ======================================================================
    function automatic shtp_byte_t packet_byte(input int k, input logic [15:0] len,
                                               input shtp_byte_t chan, input shtp_byte_t id,
                                               input logic [63:0] words, input shtp_byte_t seq);
        int          p;
        logic [15:0] w;
        p = k - `SHTP_HDR_BYTES;
        w = 16'(words >> (16 * ((p - 4) / 2)));
        if (k == 0) packet_byte = len[7:0];
        else if (k == 1) packet_byte = len[15:8];
        else if (k == 2) packet_byte = chan;
        else if (k == 3) packet_byte = seq;
        else if (p == 0) packet_byte = id;
        else if (p < 4) packet_byte = 8'h40 + 8'(p);   // Sequence, status, delay
        else if (p < 12) packet_byte = p[0] ? w[15:8] : w[7:0];
        else packet_byte = 8'ha5 ^ 8'(p);               // Trailing fields
    endfunction

    task automatic run_packet(input logic [15:0] len, input shtp_byte_t chan,
                              input shtp_byte_t id, input logic [63:0] words,
                              input logic [31:0] code, input int num);
        int masked;
        int nread;
        int start;
        int q0;
        int qc0;
        int g0;
        int gc0;
        int k;
        masked = len & 16'h7fff;
        nread  = (masked > `SHTP_HDR_BYTES && masked <= `SHTP_MAX_LEN) ?
                 masked : `SHTP_HDR_BYTES;
        pkt_q.delete();
        for (k = 0; k < nread; k++) begin
            pkt_q.push_back(packet_byte(k, len, chan, id, words, 8'(num)));
        end
        start = tx_log.size();
        q0    = quat_pulses;
        qc0   = quat_cycles;
        g0    = gyro_pulses;
        gc0   = gyro_cycles;

        @(posedge clk);
        #1 int_n = 1'b0;
        wait_cs(1'b0, 20, "chip select low at packet start");
        #1 int_n = 1'b1;
        wait_cs(1'b1, nread * 12 + 50, "end of a packet read");
        repeat (4) @(posedge clk);  // Valid strobe lands two cycles after the last byte
        #1;

        check_value("bytes read", nread, tx_log.size() - start);
        for (k = start; k < tx_log.size(); k++) begin
            check_value("spi_tx_data during read", 32'h0, tx_log[k]);
        end
        if (code == "quat") begin
            for (k = 0; k < 4; k++) exp_q[k] = words[16*k +: 16];
        end else if (code == "gyro") begin
            for (k = 0; k < 3; k++) exp_g[k] = words[16*k +: 16];
        end else if (code != "none") begin
            abort_run($sformatf("Unknown expect code in case %0d", num));
        end
        check_value("quat_valid pulses", code == "quat", quat_pulses - q0);
        check_value("quat_valid cycles", code == "quat", quat_cycles - qc0);
        check_value("gyro_valid pulses", code == "gyro", gyro_pulses - g0);
        check_value("gyro_valid cycles", code == "gyro", gyro_cycles - gc0);
        check_outputs();
    endtask

    task automatic run_cases;
        int                fd;
        int                n;
        int                num;
        logic [8*120-1:0]  line;
        logic [15:0]       len;
        shtp_byte_t        chan;
        shtp_byte_t        id;
        logic [15:0]       w[4];
        logic [31:0]       code;
        num = 0;
        fd  = $fopen("test/shtp_cases.txt", "r");
        if (fd == 0) abort_run("Could not open the case file test/shtp_cases.txt");
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines fail the first field and are skipped
            n = $sscanf(line, "%h %h %h %h %h %h %h %s",
                        len, chan, id, w[0], w[1], w[2], w[3], code);
            if (n == 8) begin
                num++;
                run_packet(len, chan, id, {w[3], w[2], w[1], w[0]}, code, num);
            end
        end
        $fclose(fd);
        if (num == 0) abort_run("The case file held no packets");
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        int tx_before;
        rst_n = 1'b0;
        int_n = 1'b1;
        apply_reset();
        run_init();
        run_cases();

        // Second reset with INT never asserted
        @(posedge clk);
        #1;
        apply_reset();
        tx_before = tx_log.size();
        wait_status(1'b1, `SHTP_RESET_WAIT + `SHTP_INT_TIMEOUT + 100, "error on INT timeout");
        repeat (20) begin
            @(posedge clk);
            check_value("error", 32'd1, error);
            check_value("cs_n", 32'd1, cs_n);
            check_value("initialized", 32'd0, initialized);
        end
        check_value("bytes sent in error state", tx_before, tx_log.size());

        $display("Test OK");
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/shtp_pkg.sv
source/shtp_rx_if.sv
source/shtp_timer.sv
source/init_cmd_rom.sv
source/shtp_sequencer.sv
source/report_parser.sv
source/bno085_controller.sv
test/tb_bno085_controller.sv

/* test/shtp_cases.txt */
# One SHTP packet per line with all numbers in hex
# length channel report_id word0 word1 word2 word3 expect (quat, gyro or none)
# Words run X Y Z W for quaternions and X Y Z for gyro reports
0012 03 05 1234 fedc 0a0b 4000 quat
000e 03 02 0100 ff00 7fff 8001 gyro
0010 05 05 8000 7fff 0001 c000 quat
0012 02 05 1111 2222 3333 4444 none
0004 03 05 5555 6666 7777 8888 none
0000 05 02 9999 aaaa bbbb cccc none
800e 05 02 abcd 00ff ff01 0000 gyro
7fff 03 05 0f0f f0f0 1357 2468 none
0015 03 01 dead beef cafe f00d none
0017 05 05 3fff c001 0200 fe00 quat
0003 03 02 1212 3434 5656 7878 none
0012 01 05 aaaa bbbb cccc dddd none
000e 05 02 8000 0000 7ffe 1111 gyro
0012 03 05 ffff 0000 8000 7fff quat
0012 02 02 4321 8765 0fed 0cba none
000e 03 02 0042 ffbe 1000 0000 gyro
